// ==== files.f ====
source/memory_packet_pkg.sv
source/merge_config_pkg.sv
source/fifo_port_if.sv
source/sync_fifo.sv
source/setup_packet_filter.sv
source/merge_config_assembler.sv
source/merge_config_top.sv
tests/merge_config_properties.sv
tests/merge_config_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the merge collector testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module merge_config_tb -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vmerge_config_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$log"; then
    echo "testbench reported failure"
    exit 1
fi

exit 0

// ==== tests/merge_config_tb.sv ====
// merge configuration collector testbench
`timescale 1ns/100ps

module merge_config_tb
    import memory_packet_pkg::*;
    import merge_config_pkg::*;
();

    localparam int seq_base    = 2;
    localparam int seq_words   = 4;
    localparam int fifo_depth  = 16;
    localparam int prog_thresh = 8;

    logic          ap_clk;
    logic          reset;
    logic          in_valid;
    packet_kind_e  in_kind;
    mem_offset_t   in_offset;
    shift_amount_t in_shift;
    data_word_t    in_data;
    logic          in_prog_full;
    logic          config_rd_en = 1'b0;
    logic          config_valid;
    merge_mask_t   config_merge_mask;
    merge_type_t   config_merge_type;
    logic          config_empty;

    logic [31:0]   lfsr_state;
    merge_config_t expected_q[$];
    merge_config_t exp_record;
    int            value_errors;
    int            other_errors;
    int            cycle_count;
    int            sent_count;
    int            read_mode;
    int            prog_full_run;
    logic          saw_prog_full;
    logic          sender_done;

    // reference model state
    logic          model_collecting;
    int            model_count;
    merge_config_t model_record;

    merge_config_top #(
        .seq_base   (seq_base),
        .seq_words  (seq_words),
        .fifo_depth (fifo_depth),
        .prog_thresh(prog_thresh)
    ) merge_config_top_inst (.*);

    initial begin
        ap_clk = 1'b0;
        forever #20 ap_clk = ~ap_clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    task automatic model_packet(input packet_kind_e kind, input mem_offset_t offset,
                                input shift_amount_t shift, input data_word_t data);
        int index;
        index = int'(offset >> shift);
        if ((kind == PKT_CU_SETUP || kind == PKT_ENGINE_SETUP) &&
            index >= seq_base && index < seq_base + seq_words &&
            (model_collecting || index == seq_base)) begin
            if (model_count == 0)
                model_record.merge_mask = data[7:0];
            if (model_count == 1)
                model_record.merge_type = data[7:0];
            if (model_count == seq_words - 1) begin
                expected_q.push_back(model_record);
                model_collecting = 1'b0;
                model_count      = 0;
            end else begin
                model_collecting = 1'b1;
                model_count++;
            end
        end
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    // waits out back-pressure, then drives one packet for a cycle
    task automatic send_packet(input packet_kind_e kind, input int index,
                               input shift_amount_t shift);
        mem_offset_t offset;
        data_word_t  data;
        // low bits below the shift do not change the index
        offset = mem_offset_t'((index << shift) | rand_bits(shift));
        data   = rand_bits(32);
        @(negedge ap_clk);
        while (in_prog_full) begin
            in_valid = 1'b0;
            @(negedge ap_clk);
        end
        in_valid  = 1'b1;
        in_kind   = kind;
        in_offset = offset;
        in_shift  = shift;
        in_data   = data;
        sent_count++;
        model_packet(kind, offset, shift, data);
    endtask

    task automatic send_noise();
        int           index;
        packet_kind_e kind;
        if (rand_bits(1)) begin
            // in-window index but a data kind
            index = seq_base + int'(rand_bits(2));
            case (rand_bits(2))
                2'd0:    kind = PKT_INVALID;
                2'd1:    kind = PKT_VERTEX_DATA;
                default: kind = PKT_EDGE_DATA;
            endcase
        end else begin
            index = int'(rand_bits(8));
            if (index >= seq_base && index < seq_base + seq_words)
                index += 8;
            if (rand_bits(1))
                kind = PKT_CU_SETUP;
            else
                kind = PKT_ENGINE_SETUP;
        end
        send_packet(kind, index, shift_amount_t'(rand_bits(3)));
    endtask

    task automatic send_window();
        int           noise;
        packet_kind_e kind;
        // stray mid-window word while idle, to be dropped
        if (rand_bits(2) == 0)
            send_packet(PKT_ENGINE_SETUP, seq_base + 1 + int'(rand_bits(1)),
                        shift_amount_t'(rand_bits(3)));
        for (int w = 0; w < seq_words; w++) begin
            noise = int'(rand_bits(2));
            repeat (noise) send_noise();
            if (rand_bits(1))
                kind = PKT_CU_SETUP;
            else
                kind = PKT_ENGINE_SETUP;
            send_packet(kind, seq_base + w, shift_amount_t'(rand_bits(3)));
        end
    endtask

    // --------------------------------------------------
    // configuration reader and checker
    // --------------------------------------------------
    always @(negedge ap_clk) begin
        if (!reset) begin
            if (config_valid && expected_q.size() == 0) begin
                other_errors++;
                $display("unexpected configuration record at cycle %0d", cycle_count);
            end else if (config_valid) begin
                exp_record = expected_q.pop_front();
                check_value("config_merge_mask", config_merge_mask, exp_record.merge_mask);
                check_value("config_merge_type", config_merge_type, exp_record.merge_type);
            end
            // mode 0 paced reads, 1 held off, 2 continuous drain
            prog_full_run = in_prog_full ? prog_full_run + 1 : 0;
            if (read_mode == 1 && in_prog_full)
                saw_prog_full = 1'b1;
            if (read_mode == 1 && (prog_full_run >= 20 || sender_done))
                read_mode = 2;
            config_rd_en = (read_mode == 2) || (read_mode == 0 && cycle_count % 3 != 0);
        end
    end

    // limit grows with the packets sent
    always @(posedge ap_clk) begin
        cycle_count++;
        if (cycle_count > 40 * sent_count + 1000) begin
            $display("timeout: run stalled after %0d cycles and %0d packets",
                     cycle_count, sent_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        reset            = 1'b1;
        in_valid         = 1'b0;
        in_kind          = PKT_INVALID;
        in_offset        = '0;
        in_shift         = '0;
        in_data          = '0;
        lfsr_state       = 32'h601d;
        value_errors     = 0;
        other_errors     = 0;
        cycle_count      = 0;
        sent_count       = 0;
        read_mode        = 0;
        prog_full_run    = 0;
        saw_prog_full    = 1'b0;
        sender_done      = 1'b0;
        model_collecting = 1'b0;
        model_count      = 0;
        model_record     = '0;
        repeat (2) @(posedge ap_clk);
        @(negedge ap_clk);
        reset = 1'b0;
        check_value("config_empty", config_empty, 1'b1);
        check_value("config_valid", config_valid, 1'b0);
        check_value("in_prog_full", in_prog_full, 1'b0);

        // windows mixed with noise, reads paced
        repeat (20) send_window();
        // reads held off until the sender has stalled
        read_mode = 1;
        repeat (16) send_window();
        @(negedge ap_clk);
        in_valid    = 1'b0;
        sender_done = 1'b1;
        while (expected_q.size() != 0) @(negedge ap_clk);
        // quiet window to catch extra records
        repeat (40) @(negedge ap_clk);
        check_value("config_empty", config_empty, 1'b1);
        if (!saw_prog_full) begin
            other_errors++;
            $display("response FIFO never reached programmable full while reads were held off");
        end

        $display("errors: %0d value mismatches, %0d other failures, %0d packets sent",
                 value_errors, other_errors, sent_count);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : merge_config_tb

// ==== tests/merge_config_properties.sv ====
// merge collector assertions
`timescale 1ns/100ps

module merge_config_properties (
    input logic ap_clk,
    input logic reset,
    input logic resp_push,
    input logic resp_full,
    input logic cfg_push,
    input logic cfg_full,
    input logic config_rd_en,
    input logic config_empty,
    input logic config_valid,
    input logic in_prog_full
);

    // --------------------------------------------------
    // FIFO overflow
    // --------------------------------------------------
    assert property (@(posedge ap_clk) disable iff (reset) !(resp_push && resp_full))
        else $error("push into a full response FIFO");

    assert property (@(posedge ap_clk) disable iff (reset) !(cfg_push && cfg_full))
        else $error("push into a full configuration FIFO");

    // read data only follows an accepted read
    assert property (@(posedge ap_clk) disable iff (reset)
        config_valid |-> $past(config_rd_en && !config_empty))
        else $error("config_valid without an accepted read in the cycle before");

    // everything quiet in the first cycle out of reset
    assert property (@(posedge ap_clk)
        reset |=> (!config_valid && !in_prog_full && config_empty && !resp_push && !cfg_push))
        else $error("outputs or strobes active right after reset");

endmodule : merge_config_properties

bind merge_config_top merge_config_properties merge_config_properties_inst (
    .ap_clk      (ap_clk),
    .reset       (reset),
    .resp_push   (resp_port.push),
    .resp_full   (resp_fifo_inst.count == resp_fifo_inst.depth_level),
    .cfg_push    (cfg_port.push),
    .cfg_full    (cfg_fifo_inst.count == cfg_fifo_inst.depth_level),
    .config_rd_en(config_rd_en),
    .config_empty(config_empty),
    .config_valid(config_valid),
    .in_prog_full(in_prog_full)
);

// ==== source/merge_config_top.sv ====
// merge configuration collector
`timescale 1ns/100ps

module merge_config_top
    import memory_packet_pkg::*;
    import merge_config_pkg::*;
#(
    parameter int seq_base    = 0,
    parameter int seq_words   = DEFAULT_SEQ_WORDS,
    parameter int fifo_depth  = DEFAULT_FIFO_DEPTH,
    parameter int prog_thresh = DEFAULT_PROG_THRESH
) (
    input  logic          ap_clk,
    input  logic          reset,
    input  logic          in_valid,
    input  packet_kind_e  in_kind,
    input  mem_offset_t   in_offset,
    input  shift_amount_t in_shift,
    input  data_word_t    in_data,
    output logic          in_prog_full,
    input  logic          config_rd_en,
    output logic          config_valid,
    output merge_mask_t   config_merge_mask,
    output merge_type_t   config_merge_type,
    output logic          config_empty
);

    response_packet_t in_packet;
    merge_config_t    cfg_record;

    fifo_port_if #(.data_width($bits(response_packet_t))) resp_port ();
    fifo_port_if #(.data_width($bits(merge_config_t)))    cfg_port ();

    assign in_packet = '{kind: in_kind, offset: in_offset, shift: in_shift, data: in_data};

    // --------------------------------------------------
    // response path
    // --------------------------------------------------
    setup_packet_filter #(
        .seq_base (seq_base),
        .seq_words(seq_words)
    ) setup_packet_filter_inst (
        .ap_clk   (ap_clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_packet(in_packet),
        .resp     (resp_port.producer)
    );

    sync_fifo #(
        .data_width ($bits(response_packet_t)),
        .fifo_depth (fifo_depth),
        .prog_thresh(prog_thresh)
    ) resp_fifo_inst (
        .ap_clk(ap_clk),
        .reset (reset),
        .port  (resp_port.fifo)
    );

    merge_config_assembler #(
        .seq_base (seq_base),
        .seq_words(seq_words)
    ) merge_config_assembler_inst (
        .ap_clk(ap_clk),
        .reset (reset),
        .resp  (resp_port.consumer),
        .cfg   (cfg_port.producer)
    );

    // --------------------------------------------------
    // configuration path
    // --------------------------------------------------
    sync_fifo #(
        .data_width ($bits(merge_config_t)),
        .fifo_depth (fifo_depth),
        .prog_thresh(prog_thresh)
    ) cfg_fifo_inst (
        .ap_clk(ap_clk),
        .reset (reset),
        .port  (cfg_port.fifo)
    );

    // consumer side of the configuration FIFO
    assign cfg_port.pop      = config_rd_en;
    assign cfg_record        = cfg_port.pop_data;
    assign config_valid      = cfg_port.pop_valid;
    assign config_merge_mask = cfg_record.merge_mask;
    assign config_merge_type = cfg_record.merge_type;
    assign config_empty      = cfg_port.empty;
    assign in_prog_full      = resp_port.prog_full;

endmodule : merge_config_top

// ==== source/merge_config_assembler.sv ====
// merge configuration assembler
`timescale 1ns/100ps

module merge_config_assembler
    import memory_packet_pkg::*;
    import merge_config_pkg::*;
#(
    parameter int seq_base  = 0,
    parameter int seq_words = DEFAULT_SEQ_WORDS
) (
    input  logic          ap_clk,
    input  logic          reset,
    fifo_port_if.consumer resp,
    fifo_port_if.producer cfg
);

    localparam int cnt_w = (seq_words > 1) ? $clog2(seq_words) : 1;

    localparam logic [cnt_w-1:0] last_word   = cnt_w'(seq_words - 1);
    localparam logic [cnt_w-1:0] second_word = cnt_w'(1);
    localparam mem_offset_t      seq_first   = mem_offset_t'(seq_base);

    assembler_state_e state;
    logic [cnt_w-1:0] word_count;
    logic             emit_pending;
    merge_config_t    record;

    response_packet_t word;
    mem_offset_t      seq_index;
    logic             word_start;
    logic             word_take;
    logic             word_last;

    // --------------------------------------------------
    // response word decode
    // --------------------------------------------------
    assign word      = resp.pop_data;
    assign seq_index = word.offset >> word.shift;

    // only the window's first index opens a window
    assign word_start = (state == ST_IDLE) && (seq_index == seq_first);
    assign word_take  = resp.pop_valid && ((state == ST_COLLECTING) || word_start);
    // word_count stays at zero while idle
    assign word_last  = (word_count == last_word);

    // hold off while the record waits to be pushed
    assign resp.pop = !resp.empty && !cfg.prog_full && !emit_pending;

    // --------------------------------------------------
    // window FSM
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            state        <= ST_IDLE;
            word_count   <= '0;
            emit_pending <= 1'b0;
        end else begin
            emit_pending <= word_take && word_last;
            if (word_take) begin
                if (word_last) begin
                    state      <= ST_IDLE;
                    word_count <= '0;
                end else begin
                    state      <= ST_COLLECTING;
                    word_count <= word_count + 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------
    // record fields
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (word_take && (word_count == '0)) begin
            record.merge_mask <= word.data[$bits(merge_mask_t)-1:0];
        end
        if (word_take && (word_count == second_word)) begin
            record.merge_type <= word.data[$bits(merge_type_t)-1:0];
        end
    end

    assign cfg.push      = emit_pending;
    assign cfg.push_data = record;

endmodule : merge_config_assembler

// ==== source/setup_packet_filter.sv ====
// setup packet window filter
`timescale 1ns/100ps

module setup_packet_filter
    import memory_packet_pkg::*;
    import merge_config_pkg::*;
#(
    parameter int seq_base  = 0,
    parameter int seq_words = DEFAULT_SEQ_WORDS
) (
    input  logic             ap_clk,
    input  logic             reset,
    input  logic             in_valid,
    input  response_packet_t in_packet,
    fifo_port_if.producer    resp
);

    // one spare bit so the window end can reach past the offset range
    localparam int idx_w = $bits(mem_offset_t) + 1;

    localparam logic [idx_w-1:0] win_lo = idx_w'(seq_base);
    localparam logic [idx_w-1:0] win_hi = idx_w'(seq_base + seq_words);

    logic             valid_reg;
    response_packet_t packet_reg;
    mem_offset_t      seq_index;
    logic             kind_ok;
    logic             in_window;

    // --------------------------------------------------
    // input register stage
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            valid_reg <= 1'b0;
        end else begin
            valid_reg <= in_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        packet_reg <= in_packet;
    end

    // --------------------------------------------------
    // filter
    // --------------------------------------------------
    assign seq_index = packet_reg.offset >> packet_reg.shift;

    assign kind_ok   = (packet_reg.kind == PKT_CU_SETUP) ||
                       (packet_reg.kind == PKT_ENGINE_SETUP);
    assign in_window = ({1'b0, seq_index} >= win_lo) && ({1'b0, seq_index} < win_hi);

    assign resp.push      = valid_reg && kind_ok && in_window;
    assign resp.push_data = packet_reg;

endmodule : setup_packet_filter

// ==== source/sync_fifo.sv ====
// synchronous FIFO
`timescale 1ns/100ps

module sync_fifo
    import merge_config_pkg::*;
#(
    parameter int data_width  = 32,
    parameter int fifo_depth  = DEFAULT_FIFO_DEPTH,
    parameter int prog_thresh = DEFAULT_PROG_THRESH
) (
    input  logic      ap_clk,
    input  logic      reset,
    fifo_port_if.fifo port
);

    localparam int addr_w  = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int count_w = $clog2(fifo_depth + 1);

    localparam logic [addr_w-1:0]  last_addr   = addr_w'(fifo_depth - 1);
    localparam logic [count_w-1:0] depth_level = count_w'(fifo_depth);
    localparam logic [count_w-1:0] prog_level  = count_w'(prog_thresh);

    logic [data_width-1:0] mem [fifo_depth];
    logic [addr_w-1:0]     wr_ptr;
    logic [addr_w-1:0]     rd_ptr;
    logic [count_w-1:0]    count;
    logic                  push_ok;
    logic                  pop_ok;

    // --------------------------------------------------
    // accepted strobes
    // --------------------------------------------------
    // push into full and pop from empty are dropped
    assign push_ok = port.push && (count != depth_level);
    assign pop_ok  = port.pop && (count != '0);

    // --------------------------------------------------
    // pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            port.pop_valid <= 1'b0;
        end else begin
            port.pop_valid <= pop_ok;
            if (push_ok) begin
                wr_ptr <= (wr_ptr == last_addr) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == last_addr) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and registered read data
    always_ff @(posedge ap_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= port.push_data;
        end
        if (pop_ok) begin
            port.pop_data <= mem[rd_ptr];
        end
    end

    assign port.empty     = (count == '0);
    assign port.prog_full = (count >= prog_level);

endmodule : sync_fifo

// ==== source/fifo_port_if.sv ====
// FIFO push and pop port
`timescale 1ns/100ps

interface fifo_port_if #(
    parameter int data_width = 32
);

    // push side
    logic                  push;
    logic [data_width-1:0] push_data;

    // pop side
    logic                  pop;
    logic [data_width-1:0] pop_data;
    logic                  pop_valid;

    // status
    logic                  empty;
    logic                  prog_full;

    modport producer (
        output push,
        output push_data,
        input  prog_full
    );

    modport fifo (
        input  push,
        input  push_data,
        input  pop,
        output pop_data,
        output pop_valid,
        output empty,
        output prog_full
    );

    // pop_valid follows an accepted pop by one cycle
    modport consumer (
        output pop,
        input  pop_data,
        input  pop_valid,
        input  empty,
        input  prog_full
    );

endinterface : fifo_port_if

// ==== source/merge_config_pkg.sv ====
// merge configuration record types
package merge_config_pkg;

    // --------------------------------------------------
    // configuration record
    // --------------------------------------------------
    // both fields come from the low byte of a data word
    typedef logic [7:0] merge_mask_t;
    typedef logic [7:0] merge_type_t;

    typedef struct packed {
        merge_mask_t merge_mask;
        merge_type_t merge_type;
    } merge_config_t;

    typedef enum logic {
        ST_IDLE       = 1'b0,
        ST_COLLECTING = 1'b1
    } assembler_state_e;

    // --------------------------------------------------
    // defaults
    // --------------------------------------------------
    localparam int DEFAULT_SEQ_WORDS   = 16;
    localparam int DEFAULT_FIFO_DEPTH  = 16;
    localparam int DEFAULT_PROG_THRESH = 8;

endpackage : merge_config_pkg

// ==== source/memory_packet_pkg.sv ====
// memory response packet types
package memory_packet_pkg;

    // --------------------------------------------------
    // packet fields
    // --------------------------------------------------
    typedef enum logic [2:0] {
        PKT_INVALID      = 3'd0,
        PKT_CU_SETUP     = 3'd1,
        PKT_ENGINE_SETUP = 3'd2,
        PKT_VERTEX_DATA  = 3'd3,
        PKT_EDGE_DATA    = 3'd4
    } packet_kind_e;

    // word offset within a buffer
    typedef logic [15:0] mem_offset_t;

    // offset >> shift gives the sequence index
    typedef logic [3:0]  shift_amount_t;

    typedef logic [31:0] data_word_t;

    // response FIFO payload, 55 bits
    typedef struct packed {
        packet_kind_e  kind;
        mem_offset_t   offset;
        shift_amount_t shift;
        data_word_t    data;
    } response_packet_t;

endpackage : memory_packet_pkg
